//--- test/vblk_vectors.txt
# name pfn count, then three entries of: head type sector buf_addr buf_len status_addr,
# then the expected used idx; unused entries are zero, heads are even and below 6
single 1 1 0 1 10 8000 200 9002 0 0 0 0 0 0 0 0 0 0 0 0 1
fill_a 1 3 0 0 20 8000 200 9101 2 1 21 8400 200 9101 4 0 22 8800 200 9101 4
fill_b 1 2 2 1 30 8000 400 9203 4 0 31 8400 400 9203 0 0 0 0 0 0 6
wrap 3 3 4 0 40 8000 200 9300 0 1 41 8400 200 9300 2 0 42 8800 200 9300 9
empty 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9

//--- compile.f
+incdir+src
src/vblk_pkg.sv
src/mmio_regs.sv
src/vq_walker.sv
src/vq_completer.sv
src/vblk_top.sv
test/vblk_asserts.sv
test/tb_vblk.sv

//--- Bender.yml
package:
  name: vblk

sources:
  - include_dirs:
      - src
    files:
      - src/vblk_pkg.sv
      - src/mmio_regs.sv
      - src/vq_walker.sv
      - src/vq_completer.sv
      - src/vblk_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/vblk_asserts.sv
      - test/tb_vblk.sv

//--- test/tb_vblk.sv
`timescale 1ns/1ps
`include "vblk_cfg.svh"

module tb_vblk;

   localparam int MAX_TESTS = 16;

   logic                clk;
   logic                rstn;
   vblk_pkg::axil_req_t core_req;
   vblk_pkg::axil_rsp_t core_rsp;
   vblk_pkg::mem_req_t  mem_req;
   vblk_pkg::mem_rsp_t  mem_rsp;
   logic                virtio_interrupt;

   int          errors;
   int          irq_count;
   int          wr_count;
   int          n_tests;
   int          total_entries;
   bit          load_done;
   logic [31:0] lcg_state;
   logic [31:0] mem [logic [31:0]];

   string       v_name   [MAX_TESTS];
   logic [31:0] v_pfn    [MAX_TESTS];
   int          v_count  [MAX_TESTS];
   int          v_exp    [MAX_TESTS];
   logic [15:0] v_head   [MAX_TESTS][3];
   logic [31:0] v_type   [MAX_TESTS][3];
   logic [63:0] v_sector [MAX_TESTS][3];
   logic [31:0] v_buf    [MAX_TESTS][3];
   logic [31:0] v_len    [MAX_TESTS][3];
   logic [31:0] v_status [MAX_TESTS][3];

   vblk_top vblk_top_i (
      .clk              (clk),
      .rstn             (rstn),
      .core_req         (core_req),
      .core_rsp         (core_rsp),
      .mem_req          (mem_req),
      .mem_rsp          (mem_rsp),
      .virtio_interrupt (virtio_interrupt)
   );

   bind vblk_top vblk_asserts vblk_asserts_i (
      .clk              (clk),
      .rstn             (rstn),
      .core_req         (core_req),
      .core_rsp         (core_rsp),
      .mem_req          (mem_req),
      .virtio_interrupt (virtio_interrupt)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   ////////////////////////////////////////
   // memory model

   function automatic logic [31:0] fill_word(logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
   endfunction

   function automatic logic [31:0] read_word(logic [31:0] addr);
      logic [31:0] key;
      key = {addr[31:2], 2'b00};
      return mem.exists(key) ? mem[key] : fill_word(key);
   endfunction

   task automatic write_strobed(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
      logic [31:0] w;
      w = read_word(addr);
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) w[8*i +: 8] = data[8*i +: 8];
      end
      mem[{addr[31:2], 2'b00}] = w;
   endtask

   // 16-bit field, high half when bit 1 is set
   task automatic write_half(logic [31:0] addr, logic [15:0] val);
      write_strobed(addr, {val, val}, addr[1] ? 4'b1100 : 4'b0011);
   endtask

   logic               busy;
   int                 wait_cnt;
   vblk_pkg::mem_req_t pend;

   // response one to four cycles after the request cycle
   always @(negedge clk) begin
      mem_rsp.valid = 1'b0;
      if (virtio_interrupt) irq_count++;
      if (busy) begin
         if (mem_req.req) begin
            errors++;
            $display("memory request issued while another was outstanding");
         end
         wait_cnt--;
         if (wait_cnt == 0) begin
            busy = 1'b0;
            if (pend.mode == vblk_pkg::MEM_WRITE) begin
               write_strobed(pend.addr, pend.wdata, pend.wstrb);
               wr_count++;
               mem_rsp.rdata = 32'h0;
            end else begin
               mem_rsp.rdata = read_word(pend.addr);
            end
            mem_rsp.valid = 1'b1;
         end
      end else if (mem_req.req) begin
         pend     = mem_req;
         busy     = 1'b1;
         wait_cnt = 1 + int'(lcg_next() % 4);
      end
   end

   ////////////////////////////////////////
   // axi4-lite master

   task automatic report_mismatch(string test, string what, logic [31:0] exp, logic [31:0] act);
      errors++;
      $display("** Error [%s] %s: expected %h, actual %h", test, what, exp, act);
   endtask

   task automatic axi_write(string test, logic [31:0] addr, logic [31:0] data);
      logic aw_hs;
      logic w_hs;
      int   span;
      core_req.awaddr  = addr;
      core_req.awvalid = 1'b1;
      core_req.wdata   = data;
      core_req.wvalid  = 1'b1;
      do begin
         aw_hs = core_req.awvalid && core_rsp.awready;
         w_hs  = core_req.wvalid && core_rsp.wready;
         @(negedge clk);
         if (aw_hs) core_req.awvalid = 1'b0;
         if (w_hs) core_req.wvalid = 1'b0;
      end while (core_req.awvalid || core_req.wvalid);
      while (!core_rsp.bvalid) @(negedge clk);
      if (core_rsp.bresp !== 2'b00) begin
         report_mismatch(test, "bresp", 32'h0, {30'h0, core_rsp.bresp});
      end
      span = int'(lcg_next() % 6);
      repeat (span) begin
         @(negedge clk);
         if (!core_rsp.bvalid) begin
            errors++;
            $display("[%s] bvalid fell while bready was low", test);
         end
      end
      core_req.bready = 1'b1;
      @(negedge clk);
      core_req.bready = 1'b0;
   endtask

   task automatic axi_read(string test, logic [31:0] addr, output logic [31:0] data);
      logic ar_hs;
      int   span;
      core_req.araddr  = addr;
      core_req.arvalid = 1'b1;
      do begin
         ar_hs = core_rsp.arready;
         @(negedge clk);
      end while (!ar_hs);
      core_req.arvalid = 1'b0;
      if (!core_rsp.rvalid) begin
         errors++;
         $display("[%s] rvalid did not rise the cycle after the read address", test);
      end
      if (core_rsp.rresp !== 2'b00) begin
         report_mismatch(test, "rresp", 32'h0, {30'h0, core_rsp.rresp});
      end
      data = core_rsp.rdata;
      span = int'(lcg_next() % 6);
      repeat (span) begin
         @(negedge clk);
         if (!core_rsp.rvalid || core_rsp.rdata !== data) begin
            errors++;
            $display("[%s] read data did not hold while rready was low", test);
         end
      end
      core_req.rready = 1'b1;
      @(negedge clk);
      core_req.rready = 1'b0;
   endtask

   task automatic expect_reg(string test, logic [11:0] off, logic [31:0] exp);
      logic [31:0] val;
      axi_read(test, {20'h0, off}, val);
      if (val !== exp) report_mismatch(test, $sformatf("reg %h", off), exp, val);
   endtask

   ////////////////////////////////////////
   // tests

   task automatic reg_tests();
      logic [31:0] val;
      expect_reg("const", `VBLK_REG_MAGIC, 32'h7472_6976);
      expect_reg("const", `VBLK_REG_VERSION, 32'h1);
      expect_reg("const", `VBLK_REG_DEVICE_ID, 32'h2);
      expect_reg("const", `VBLK_REG_VENDOR_ID, 32'h554d_4551);
      expect_reg("const", `VBLK_REG_QUEUE_NUM_MAX, 32'd8);
      axi_write("const", `VBLK_REG_QUEUE_SEL, 32'h1);
      expect_reg("const", `VBLK_REG_QUEUE_NUM_MAX, 32'h0);
      axi_write("const", `VBLK_REG_QUEUE_SEL, 32'h0);
      expect_reg("const", 12'h0fc, 32'h0);
      expect_reg("const", 12'h018, 32'h0);
      val = lcg_next();
      axi_write("rw", `VBLK_REG_QUEUE_PFN, val);
      expect_reg("rw", `VBLK_REG_QUEUE_PFN, val);
      val = lcg_next();
      axi_write("rw", `VBLK_REG_HOST_FEATURES_SEL, val);
      expect_reg("rw", `VBLK_REG_HOST_FEATURES_SEL, val);
      val = lcg_next();
      axi_write("rw", `VBLK_REG_STATUS, val);
      expect_reg("rw", `VBLK_REG_STATUS, val);
   endtask

   task automatic write_desc(logic [31:0] base, int idx, logic [31:0] addr,
                             logic [31:0] len, logic [15:0] flags, logic [15:0] next);
      logic [31:0] d;
      d = base + 32'(idx) * 16;
      mem[d]      = addr;
      mem[d + 4]  = 32'h0;
      mem[d + 8]  = len;
      mem[d + 12] = {next, flags};
   endtask

   task automatic run_vector(int t, inout int start);
      logic [31:0] desc_head;
      logic [31:0] avail_head;
      logic [31:0] used_head;
      logic [31:0] hdr;
      logic [31:0] st_word;
      logic [31:0] st_pre [3];
      logic [31:0] exp_st;
      logic [31:0] slot_addr;
      logic [31:0] got;
      int          h;
      int          slot;
      int          cyc;
      int          wr_before;
      int          irq_before;
      string       name;
      name       = v_name[t];
      desc_head  = v_pfn[t] << 12;
      avail_head = desc_head + 8 * 16;
      used_head  = (avail_head + 32'd4095) & ~32'd4095;
      for (int k = 0; k < v_count[t]; k++) begin
         h    = int'(v_head[t][k]);
         slot = (start + k) % 8;
         hdr  = 32'h6000 + 32'(h) * 32;
         write_half(avail_head + 4 + 32'(slot) * 2, v_head[t][k]);
         mem[hdr]      = v_type[t][k];
         mem[hdr + 8]  = v_sector[t][k][31:0];
         mem[hdr + 12] = v_sector[t][k][63:32];
         // header, data buffer, status byte, the last shared by all entries
         write_desc(desc_head, h, hdr, 32'd16, 16'h0001, 16'(h + 1));
         write_desc(desc_head, h + 1, v_buf[t][k], v_len[t][k], 16'h0003, 16'd7);
         write_desc(desc_head, 7, v_status[t][k], 32'd1, 16'h0002, 16'd0);
         st_word = {v_status[t][k][31:2], 2'b00};
         mem[st_word] = fill_word(st_word);
         st_pre[k] = mem[st_word];
         slot_addr = used_head + 4 + 32'(slot) * 8;
         mem[slot_addr]     = fill_word(slot_addr);
         mem[slot_addr + 4] = fill_word(slot_addr + 4);
      end
      write_half(avail_head + 2, 16'(start + v_count[t]));
      wr_before  = wr_count;
      irq_before = irq_count;
      axi_write(name, `VBLK_REG_QUEUE_PFN, v_pfn[t]);
      axi_write(name, `VBLK_REG_QUEUE_NOTIFY, 32'h0);
      cyc = 0;
      while (irq_count == irq_before && cyc < 2000 * (v_count[t] + 1)) begin
         @(negedge clk);
         cyc++;
      end
      if (irq_count == irq_before) begin
         errors++;
         $display("[%s] no interrupt within %0d cycles", name, cyc);
      end
      repeat (20) @(negedge clk);
      if (irq_count - irq_before != 1) begin
         report_mismatch(name, "interrupt pulses", 32'd1, 32'(irq_count - irq_before));
      end
      got = read_word(used_head);
      if (got[15:0] !== 16'(v_exp[t])) begin
         report_mismatch(name, "used idx", 32'(v_exp[t]), {16'h0, got[15:0]});
      end
      for (int k = 0; k < v_count[t]; k++) begin
         slot      = (start + k) % 8;
         slot_addr = used_head + 4 + 32'(slot) * 8;
         got       = read_word(slot_addr);
         if (got !== {16'h0, v_head[t][k]}) begin
            report_mismatch(name, $sformatf("used id slot %0d", slot),
                            {16'h0, v_head[t][k]}, got);
         end
         got = read_word(slot_addr + 4);
         if (got !== 32'h0) report_mismatch(name, $sformatf("used len slot %0d", slot), 0, got);
         exp_st = st_pre[k];
         exp_st[8 * v_status[t][k][1:0] +: 8] = 8'h00;
         got = read_word(v_status[t][k]);
         if (got !== exp_st) report_mismatch(name, "status word", exp_st, got);
      end
      if (v_count[t] == 0 && wr_count != wr_before) begin
         report_mismatch(name, "memory writes", 32'd0, 32'(wr_count - wr_before));
      end
      start = v_exp[t];
   endtask

   task automatic load_vectors();
      int    fd;
      int    n;
      string line;
      fd = $fopen("test/vblk_vectors.txt", "r");
      if (fd == 0) begin
         $display("cannot open the vector file");
         $display("*** FAILED ***");
         $finish;
      end else begin
         while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line,
               "%s %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
               v_name[n_tests], v_pfn[n_tests], v_count[n_tests],
               v_head[n_tests][0], v_type[n_tests][0], v_sector[n_tests][0],
               v_buf[n_tests][0], v_len[n_tests][0], v_status[n_tests][0],
               v_head[n_tests][1], v_type[n_tests][1], v_sector[n_tests][1],
               v_buf[n_tests][1], v_len[n_tests][1], v_status[n_tests][1],
               v_head[n_tests][2], v_type[n_tests][2], v_sector[n_tests][2],
               v_buf[n_tests][2], v_len[n_tests][2], v_status[n_tests][2],
               v_exp[n_tests]);
            if (n != 22) begin
               errors++;
               $display("malformed vector line: %s", line);
            end else begin
               total_entries += v_count[n_tests];
               n_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////
   // watchdog and main sequence

   initial begin
      int limit;
      wait (load_done);
      limit = 2000 * (total_entries + n_tests) + 5000;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      int start;
      int assert_fails;
      core_req  = '0;
      mem_rsp   = '0;
      rstn      = 1'b1;
      busy      = 1'b0;
      errors    = 0;
      irq_count = 0;
      wr_count  = 0;
      n_tests   = 0;
      start     = 0;
      lcg_state = 32'hac7c_9ccf;
      load_vectors();
      load_done = 1'b1;
      repeat (16) @(negedge clk);
      rstn = 1'b0;
      repeat (2) @(negedge clk);
      reg_tests();
      for (int t = 0; t < n_tests; t++) begin
         run_vector(t, start);
      end
      assert_fails = vblk_top_i.vblk_asserts_i.fail_count;
      $display("tests: %0d, errors: %0d, assertion failures: %0d",
               n_tests, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- test/vblk_asserts.sv
`timescale 1ns/1ps

module vblk_asserts (
   input logic                clk,
   input logic                rstn,
   input vblk_pkg::axil_req_t core_req,
   input vblk_pkg::axil_rsp_t core_rsp,
   input vblk_pkg::mem_req_t  mem_req,
   input logic                virtio_interrupt
);

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   ////////////////////////////////////////
   // axi4-lite response channels

   rvalid_held: assert property (@(posedge clk) disable iff (rstn)
      core_rsp.rvalid && !core_req.rready |=> core_rsp.rvalid && $stable(core_rsp.rdata))
      else begin
         fail_count++;
         $error("rvalid or rdata changed before rready");
      end

   bvalid_held: assert property (@(posedge clk) disable iff (rstn)
      core_rsp.bvalid && !core_req.bready |=> core_rsp.bvalid)
      else begin
         fail_count++;
         $error("bvalid fell before bready");
      end

   ////////////////////////////////////////
   // pulses

   mem_req_pulse: assert property (@(posedge clk) disable iff (rstn)
      mem_req.req |=> !mem_req.req)
      else begin
         fail_count++;
         $error("memory request longer than one cycle");
      end

   irq_pulse: assert property (@(posedge clk) disable iff (rstn)
      virtio_interrupt |=> !virtio_interrupt)
      else begin
         fail_count++;
         $error("interrupt longer than one cycle");
      end

endmodule

//--- src/vblk_top.sv
`timescale 1ns/1ps

module vblk_top (
   input  logic                clk,
   input  logic                rstn,
   input  vblk_pkg::axil_req_t core_req,
   output vblk_pkg::axil_rsp_t core_rsp,
   output vblk_pkg::mem_req_t  mem_req,
   input  vblk_pkg::mem_rsp_t  mem_rsp,
   output logic                virtio_interrupt
);

   logic               notify;
   logic [31:0]        queue_pfn;
   vblk_pkg::mem_req_t walk_mem;
   vblk_pkg::blk_req_t blk_req;
   logic               req_valid;
   logic               cpl_done;

   ////////////////////////////////////////
   // register file

   mmio_regs mmio_regs_i (
      .clk       (clk),
      .rstn      (rstn),
      .core_req  (core_req),
      .core_rsp  (core_rsp),
      .notify    (notify),
      .queue_pfn (queue_pfn)
   );

   ////////////////////////////////////////
   // queue walk and completion

   vq_walker vq_walker_i (
      .clk              (clk),
      .rstn             (rstn),
      .notify           (notify),
      .queue_pfn        (queue_pfn),
      .walk_mem         (walk_mem),
      .mem_rsp          (mem_rsp),
      .req              (blk_req),
      .req_valid        (req_valid),
      .cpl_done         (cpl_done),
      .virtio_interrupt (virtio_interrupt)
   );

   // owns the memory port, responses fan out to both
   vq_completer vq_completer_i (
      .clk       (clk),
      .rstn      (rstn),
      .walk_mem  (walk_mem),
      .req       (blk_req),
      .req_valid (req_valid),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp),
      .cpl_done  (cpl_done)
   );

endmodule

//--- src/vq_completer.sv
`timescale 1ns/1ps
`include "vblk_cfg.svh"

module vq_completer (
   input  logic               clk,
   input  logic               rstn,
   input  vblk_pkg::mem_req_t walk_mem,
   input  vblk_pkg::blk_req_t req,
   input  logic               req_valid,
   output vblk_pkg::mem_req_t mem_req,
   input  vblk_pkg::mem_rsp_t mem_rsp,
   output logic               cpl_done
);

   vblk_pkg::cpl_state_e state;
   vblk_pkg::blk_req_t   cur;
   vblk_pkg::mem_req_t   wr;
   logic        in_flight;
   logic        rsp_ok;
   logic [15:0] prev_idx;
   logic [31:0] slot_addr;

   assign rsp_ok = in_flight && mem_rsp.valid;

   // used element of the entry just walked, id then len
   assign prev_idx  = cur.used_idx - 16'd1;
   assign slot_addr = cur.used_head + 32'd4 + (32'(prev_idx) % `VBLK_QUEUE_NUM) * 8;

   // walker owns the port while no completion runs
   assign mem_req = (state == vblk_pkg::CPL_IDLE) ? walk_mem : wr;

   task automatic issue_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
      wr.req    <= 1'b1;
      wr.mode   <= vblk_pkg::MEM_WRITE;
      wr.addr   <= addr;
      wr.wdata  <= data;
      wr.wstrb  <= strb;
      in_flight <= 1'b1;
   endtask

   always_ff @(posedge clk) begin
      if (rstn) begin
         state     <= vblk_pkg::CPL_IDLE;
         wr.req    <= 1'b0;
         in_flight <= 1'b0;
         cpl_done  <= 1'b0;
      end else begin
         wr.req   <= 1'b0;
         cpl_done <= 1'b0;
         if (rsp_ok) begin
            in_flight <= 1'b0;
         end
         case (state)
            vblk_pkg::CPL_IDLE: begin
               if (req_valid) begin
                  cur <= req;
                  // status OK, one byte lane
                  issue_write({req.status_addr[31:2], 2'b00}, 32'h0,
                              4'b0001 << req.status_addr[1:0]);
                  state <= vblk_pkg::CPL_STATUS;
               end
            end
            vblk_pkg::CPL_STATUS: begin
               if (rsp_ok) begin
                  issue_write(cur.used_head, {16'h0, cur.used_idx}, 4'b0011);
                  state <= vblk_pkg::CPL_USED_IDX;
               end
            end
            vblk_pkg::CPL_USED_IDX: begin
               if (rsp_ok) begin
                  issue_write(slot_addr, {16'h0, cur.head_idx}, 4'b1111);
                  state <= vblk_pkg::CPL_USED_ID;
               end
            end
            vblk_pkg::CPL_USED_ID: begin
               if (rsp_ok) begin
                  // no data moves, so length 0
                  issue_write(slot_addr + 32'd4, 32'h0, 4'b1111);
                  state <= vblk_pkg::CPL_USED_LEN;
               end
            end
            vblk_pkg::CPL_USED_LEN: begin
               if (rsp_ok) begin
                  cpl_done <= 1'b1;
                  state    <= vblk_pkg::CPL_IDLE;
               end
            end
            default: state <= vblk_pkg::CPL_IDLE;
         endcase
      end
   end

endmodule

//--- src/vq_walker.sv
`timescale 1ns/1ps
`include "vblk_cfg.svh"

module vq_walker (
   input  logic               clk,
   input  logic               rstn,
   input  logic               notify,
   input  logic [31:0]        queue_pfn,
   output vblk_pkg::mem_req_t walk_mem,
   input  vblk_pkg::mem_rsp_t mem_rsp,
   output vblk_pkg::blk_req_t req,
   output logic               req_valid,
   input  logic               cpl_done,
   output logic               virtio_interrupt
);

   vblk_pkg::walk_state_e state;
   logic [31:0] desc_head;
   logic [31:0] avail_head;
   logic [31:0] used_head;
   logic [15:0] used_idx;
   logic [15:0] cur_idx;
   logic [31:0] cur_addr;
   logic [1:0]  desc_n;
   logic [1:0]  word_n;
   logic        in_flight;
   logic        half_hi;
   logic        rsp_ok;
   logic [15:0] rsp_half;
   logic [31:0] next_off;

   // ring layout from the pfn
   assign desc_head  = queue_pfn << `VBLK_PAGE_SHIFT;
   assign avail_head = desc_head + `VBLK_QUEUE_NUM * `VBLK_DESC_BYTES;
   assign used_head  = (avail_head + `VBLK_QUEUE_ALIGN - 1) & ~(`VBLK_QUEUE_ALIGN - 1);

   assign rsp_ok   = in_flight && mem_rsp.valid;
   assign rsp_half = half_hi ? mem_rsp.rdata[31:16] : mem_rsp.rdata[15:0];
   // descriptor and header words sit at +0, +8, +12
   assign next_off = (word_n == 2'd0) ? 32'd8 : 32'd12;

   assign req_valid        = (state == vblk_pkg::HANDOFF);
   assign virtio_interrupt = (state == vblk_pkg::IRQ);

   function automatic logic [31:0] desc_addr(logic [15:0] idx);
      desc_addr = desc_head + (32'(idx) % `VBLK_QUEUE_NUM) * `VBLK_DESC_BYTES;
   endfunction

   // word read, the half select follows bit 1 of the field address
   task automatic issue_read(logic [31:0] addr);
      walk_mem.req   <= 1'b1;
      walk_mem.mode  <= vblk_pkg::MEM_READ;
      walk_mem.addr  <= {addr[31:2], 2'b00};
      walk_mem.wdata <= 32'h0;
      walk_mem.wstrb <= 4'h0;
      in_flight      <= 1'b1;
      half_hi        <= addr[1];
   endtask

   always_ff @(posedge clk) begin
      if (rstn) begin
         state        <= vblk_pkg::IDLE;
         walk_mem.req <= 1'b0;
         in_flight    <= 1'b0;
         used_idx     <= 16'h0;
      end else begin
         walk_mem.req <= 1'b0;
         if (rsp_ok) begin
            in_flight <= 1'b0;
         end
         case (state)
            vblk_pkg::IDLE: begin
               if (notify) begin
                  issue_read(avail_head + 32'd2);
                  state <= vblk_pkg::READ_AVAIL_IDX;
               end
            end
            vblk_pkg::READ_AVAIL_IDX: begin
               if (rsp_ok) begin
                  if (rsp_half != used_idx) begin
                     issue_read(avail_head + 32'd4 + (32'(used_idx) % `VBLK_QUEUE_NUM) * 2);
                     used_idx <= used_idx + 16'd1;
                     state    <= vblk_pkg::READ_HEAD;
                  end else begin
                     state <= vblk_pkg::IRQ;
                  end
               end
            end
            vblk_pkg::READ_HEAD: begin
               if (rsp_ok) begin
                  req.head_idx  <= rsp_half;
                  req.used_idx  <= used_idx;
                  req.used_head <= used_head;
                  cur_idx       <= rsp_half;
                  desc_n        <= 2'd0;
                  word_n        <= 2'd0;
                  issue_read(desc_addr(rsp_half));
                  state <= vblk_pkg::LOAD_DESC;
               end
            end
            vblk_pkg::LOAD_DESC: begin
               if (rsp_ok) begin
                  word_n <= word_n + 2'd1;
                  case (word_n)
                     2'd0: begin
                        cur_addr <= mem_rsp.rdata;
                        if (desc_n == 2'd1) begin
                           req.buf_addr <= mem_rsp.rdata;
                        end
                        if (desc_n == 2'd2) begin
                           req.status_addr <= mem_rsp.rdata;
                        end
                     end
                     2'd1: begin
                        if (desc_n == 2'd1) begin
                           req.buf_len <= mem_rsp.rdata;
                        end
                     end
                     default: begin
                        // next field, high half of the word at +12
                        cur_idx <= mem_rsp.rdata[31:16];
                     end
                  endcase
                  if (word_n != 2'd2) begin
                     issue_read(desc_addr(cur_idx) + next_off);
                  end else begin
                     word_n <= 2'd0;
                     case (desc_n)
                        2'd0: begin
                           issue_read(cur_addr);
                           state <= vblk_pkg::READ_HDR;
                        end
                        2'd1: begin
                           desc_n <= 2'd2;
                           issue_read(desc_addr(mem_rsp.rdata[31:16]));
                        end
                        default: state <= vblk_pkg::HANDOFF;
                     endcase
                  end
               end
            end
            vblk_pkg::READ_HDR: begin
               if (rsp_ok) begin
                  word_n <= word_n + 2'd1;
                  case (word_n)
                     2'd0:    req.btype         <= vblk_pkg::blk_type_e'(mem_rsp.rdata);
                     2'd1:    req.sector[31:0]  <= mem_rsp.rdata;
                     default: req.sector[63:32] <= mem_rsp.rdata;
                  endcase
                  if (word_n != 2'd2) begin
                     issue_read(cur_addr + next_off);
                  end else begin
                     word_n <= 2'd0;
                     desc_n <= 2'd1;
                     issue_read(desc_addr(cur_idx));
                     state <= vblk_pkg::LOAD_DESC;
                  end
               end
            end
            vblk_pkg::HANDOFF: state <= vblk_pkg::WAIT_DONE;
            vblk_pkg::WAIT_DONE: begin
               // recheck the avail index for entries added meanwhile
               if (cpl_done) begin
                  issue_read(avail_head + 32'd2);
                  state <= vblk_pkg::READ_AVAIL_IDX;
               end
            end
            default: state <= vblk_pkg::IDLE;
         endcase
      end
   end

endmodule

//--- src/mmio_regs.sv
`timescale 1ns/1ps
`include "vblk_cfg.svh"

module mmio_regs (
   input  logic                clk,
   input  logic                rstn,
   input  vblk_pkg::axil_req_t core_req,
   output vblk_pkg::axil_rsp_t core_rsp,
   output logic                notify,
   output logic [31:0]         queue_pfn
);

   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic        awready;
   logic        wready;
   logic        bvalid;
   logic [11:0] wr_off;
   logic [31:0] wr_data;
   logic [31:0] host_features_sel;
   logic [31:0] queue_sel;
   logic [31:0] device_status;
   logic [31:0] rd_val;
   logic        commit;

   // both halves taken, response not yet out
   assign commit = !awready && !wready && !bvalid;

   always_comb begin
      case (core_req.araddr[11:0])
         `VBLK_REG_MAGIC:             rd_val = `VBLK_MAGIC;
         `VBLK_REG_VERSION:           rd_val = `VBLK_VERSION;
         `VBLK_REG_DEVICE_ID:         rd_val = `VBLK_DEVICE_ID;
         `VBLK_REG_VENDOR_ID:         rd_val = `VBLK_VENDOR_ID;
         `VBLK_REG_HOST_FEATURES:     rd_val = 32'h0;
         `VBLK_REG_HOST_FEATURES_SEL: rd_val = host_features_sel;
         `VBLK_REG_QUEUE_NUM_MAX:     rd_val = (queue_sel == 32'h0) ? `VBLK_QUEUE_NUM : 32'h0;
         `VBLK_REG_QUEUE_PFN:         rd_val = queue_pfn;
         `VBLK_REG_STATUS:            rd_val = device_status;
         default:                     rd_val = 32'h0;
      endcase
   end

   ////////////////////////////////////////
   // read channel

   always_ff @(posedge clk) begin
      if (rstn) begin
         arready <= 1'b1;
         rvalid  <= 1'b0;
      end else if (rvalid) begin
         if (core_req.rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
         end
      end else if (arready && core_req.arvalid) begin
         arready <= 1'b0;
         rvalid  <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (arready && core_req.arvalid) begin
         rdata <= rd_val;
      end
      if (awready && core_req.awvalid) begin
         wr_off <= core_req.awaddr[11:0];
      end
      if (wready && core_req.wvalid) begin
         wr_data <= core_req.wdata;
      end
   end

   ////////////////////////////////////////
   // write channels

   always_ff @(posedge clk) begin
      if (rstn) begin
         awready           <= 1'b1;
         wready            <= 1'b1;
         bvalid            <= 1'b0;
         notify            <= 1'b0;
         host_features_sel <= 32'h0;
         queue_sel         <= 32'h0;
         queue_pfn         <= 32'h0;
         device_status     <= 32'h0;
      end else begin
         notify <= 1'b0;
         if (awready && core_req.awvalid) begin
            awready <= 1'b0;
         end
         if (wready && core_req.wvalid) begin
            wready <= 1'b0;
         end
         if (commit) begin
            bvalid <= 1'b1;
            notify <= (wr_off == `VBLK_REG_QUEUE_NOTIFY);
            case (wr_off)
               `VBLK_REG_HOST_FEATURES_SEL: host_features_sel <= wr_data;
               `VBLK_REG_QUEUE_SEL:         queue_sel         <= wr_data;
               `VBLK_REG_QUEUE_PFN:         queue_pfn         <= wr_data;
               `VBLK_REG_STATUS:            device_status     <= wr_data;
               // taken, but nothing here depends on them
               `VBLK_REG_GUEST_FEATURES, `VBLK_REG_GUEST_FEATURES_SEL,
               `VBLK_REG_GUEST_PAGE_SIZE, `VBLK_REG_QUEUE_ALIGN,
               `VBLK_REG_QUEUE_NOTIFY, `VBLK_REG_INTERRUPT_ACK: ;
               default: ;
            endcase
         end
         if (bvalid && core_req.bready) begin
            bvalid  <= 1'b0;
            awready <= 1'b1;
            wready  <= 1'b1;
         end
      end
   end

   assign core_rsp = '{
      arready: arready,
      rdata:   rdata,
      rresp:   2'b00,
      rvalid:  rvalid,
      bresp:   2'b00,
      bvalid:  bvalid,
      awready: awready,
      wready:  wready
   };

endmodule

//--- src/vblk_pkg.sv
package vblk_pkg;

   ////////////////////////////////////////
   // axi4-lite slave port

   typedef struct packed {
      logic [31:0] araddr;
      logic        arvalid;
      logic        rready;
      logic [31:0] awaddr;
      logic        awvalid;
      logic [31:0] wdata;
      logic        wvalid;
      logic        bready;
   } axil_req_t;

   typedef struct packed {
      logic        arready;
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic        rvalid;
      logic [1:0]  bresp;
      logic        bvalid;
      logic        awready;
      logic        wready;
   } axil_rsp_t;

   ////////////////////////////////////////
   // memory port, pulse in and pulse out

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_mode_e;

   typedef struct packed {
      logic        req;
      mem_mode_e   mode;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } mem_req_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] rdata;
   } mem_rsp_t;

   ////////////////////////////////////////
   // block requests and state machines

   typedef enum logic [31:0] {
      T_IN  = 32'd0,
      T_OUT = 32'd1
   } blk_type_e;

   // one walked chain, plus where its used entry goes
   typedef struct packed {
      logic [15:0] head_idx;
      blk_type_e   btype;
      logic [63:0] sector;
      logic [31:0] buf_addr;
      logic [31:0] buf_len;
      logic [31:0] status_addr;
      logic [15:0] used_idx;
      logic [31:0] used_head;
   } blk_req_t;

   typedef enum logic [3:0] {
      IDLE, READ_AVAIL_IDX, READ_HEAD, LOAD_DESC,
      READ_HDR, HANDOFF, WAIT_DONE, IRQ
   } walk_state_e;

   typedef enum logic [2:0] {
      CPL_IDLE, CPL_STATUS, CPL_USED_IDX, CPL_USED_ID, CPL_USED_LEN
   } cpl_state_e;

endpackage

//--- src/vblk_cfg.svh
`ifndef VBLK_CFG_SVH
`define VBLK_CFG_SVH

// constant register values, magic is "virt" in ascii
`define VBLK_MAGIC       32'h7472_6976
`define VBLK_VERSION     32'h0000_0001
`define VBLK_DEVICE_ID   32'h0000_0002
`define VBLK_VENDOR_ID   32'h554d_4551

// split virtqueue geometry
`define VBLK_QUEUE_NUM   8
`define VBLK_QUEUE_ALIGN 4096
`define VBLK_PAGE_SHIFT  12
`define VBLK_DESC_BYTES  16

// legacy mmio register offsets
`define VBLK_REG_MAGIC              12'h000
`define VBLK_REG_VERSION            12'h004
`define VBLK_REG_DEVICE_ID          12'h008
`define VBLK_REG_VENDOR_ID          12'h00c
`define VBLK_REG_HOST_FEATURES      12'h010
`define VBLK_REG_HOST_FEATURES_SEL  12'h014
`define VBLK_REG_GUEST_FEATURES     12'h020
`define VBLK_REG_GUEST_FEATURES_SEL 12'h024
`define VBLK_REG_GUEST_PAGE_SIZE    12'h028
`define VBLK_REG_QUEUE_SEL          12'h030
`define VBLK_REG_QUEUE_NUM_MAX      12'h034
`define VBLK_REG_QUEUE_ALIGN        12'h03c
`define VBLK_REG_QUEUE_PFN          12'h040
`define VBLK_REG_QUEUE_NOTIFY       12'h050
`define VBLK_REG_INTERRUPT_ACK      12'h064
`define VBLK_REG_STATUS             12'h070

`endif
